// File: verilog.f
verilog/cpu_pkg.sv
verilog/instr_memory.sv
verilog/instruction_fetch.sv
verilog/jump_resolver.sv
verilog/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// File: tb/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import cpu_pkg::*;

    localparam int MEM_WORDS   = 64;
    localparam int MEM_LATENCY = 2;
    localparam int PROG_WORDS  = 48;
    localparam int NUM_ISSUES  = 60;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;

    // Word slots of the four jumps and their targets
    localparam int JAL_A = 10;  // Forward over the middle block
    localparam int JAL_B = 34;  // Backward into the block that JAL_A skipped
    localparam int JAL_C = 17;  // Forward again, past JAL_B
    localparam int JAL_D = 45;  // Final self-loop

    logic            f_clk;
    logic            f_rst;
    logic            run;
    logic            stall_in;
    logic            load_en;
    logic [XLEN-1:0] load_addr;
    logic [XLEN-1:0] load_data;
    wire             issue_valid;
    wire  [XLEN-1:0] issue_instr;
    wire  [XLEN-1:0] issue_pc;
    wire             stall_out;
    wire  [31:0]     mismatch_count;
    wire  [31:0]     rule_count;
    wire  [31:0]     issue_count;
    wire             timed_out;
    logic            stim_done;
    logic [XLEN-1:0] program_words [PROG_WORDS];

    fetch_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) UUT (
        .f_clk       (f_clk),
        .f_rst       (f_rst),
        .run         (run),
        .stall_in    (stall_in),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .stall_out   (stall_out)
    );

    fetch_checker #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY),
        .NUM_ISSUES  (NUM_ISSUES)
    ) u_check (
        .f_clk          (f_clk),
        .f_rst          (f_rst),
        .run            (run),
        .stall_in       (stall_in),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .issue_valid    (issue_valid),
        .issue_instr    (issue_instr),
        .issue_pc       (issue_pc),
        .stall_out      (stall_out),
        .mismatch_count (mismatch_count),
        .rule_count     (rule_count),
        .issue_count    (issue_count),
        .timed_out      (timed_out)
    );

    // JAL with a byte offset, in the J-type field order
    function automatic logic [XLEN-1:0] encode_jal(input int offset, input logic [4:0] rd);
        logic [20:0] imm;
        imm = 21'(offset);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [XLEN-1:0] plain_word();
        logic [XLEN-1:0] w;
        w = $urandom;
        if (w[6:0] == OP_JAL) begin
            w[6:0] = 7'b0010011;  // Turn a chance JAL into an ALU immediate op
        end
        return w;
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            program_words[i] = plain_word();
        end
        program_words[JAL_A] = encode_jal((30 - JAL_A) * INSTR_BYTES, 5'd1);
        program_words[JAL_B] = encode_jal((12 - JAL_B) * INSTR_BYTES, 5'd1);
        program_words[JAL_C] = encode_jal((40 - JAL_C) * INSTR_BYTES, 5'd0);
        program_words[JAL_D] = encode_jal(0, 5'd0);
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge f_clk);
            #DRIVE_DELAY;
            load_en   = 1'b1;
            load_addr = XLEN'(i * INSTR_BYTES);
            load_data = program_words[i];
        end
        @(posedge f_clk);
        #DRIVE_DELAY;
        load_en = 1'b0;
    endtask

    initial begin
        f_clk = 1'b0;
        forever #(CLK_PERIOD / 2) f_clk = ~f_clk;
    end

    initial begin
        int seed_val;
        f_rst     = 1'b0;
        run       = 1'b0;
        stall_in  = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        stim_done = 1'b0;
        seed_val  = $urandom(45);
        build_program();
        repeat (3) @(posedge f_clk);
        #DRIVE_DELAY f_rst = 1'b1;
        load_program();
        repeat (4) @(posedge f_clk);  // Outputs must stay quiet here
        #DRIVE_DELAY run = 1'b1;
        while (issue_count < NUM_ISSUES && !timed_out) begin
            @(posedge f_clk);
        end
        stim_done = 1'b1;
        $display("Errors: %0d mismatches, %0d other failures, %0d words issued",
                 mismatch_count, rule_count, issue_count);
        if (mismatch_count == 0 && rule_count == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Random stall bursts of 1 to 6 cycles once fetching runs
    initial begin
        int gap;
        int len;
        wait (run === 1'b1);
        while (!stim_done) begin
            gap = 2 + ($urandom % 9);
            repeat (gap) @(posedge f_clk);
            #DRIVE_DELAY stall_in = 1'b1;
            len = 1 + ($urandom % 6);
            repeat (len) @(posedge f_clk);
            #DRIVE_DELAY stall_in = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker #(
    parameter int MEM_WORDS   = 64,
    parameter int MEM_LATENCY = 2,
    parameter int NUM_ISSUES  = 60
) (
    input  wire                      f_clk,
    input  wire                      f_rst,
    input  wire                      run,
    input  wire                      stall_in,
    input  wire                      load_en,
    input  wire  [cpu_pkg::XLEN-1:0] load_addr,
    input  wire  [cpu_pkg::XLEN-1:0] load_data,
    input  wire                      issue_valid,
    input  wire  [cpu_pkg::XLEN-1:0] issue_instr,
    input  wire  [cpu_pkg::XLEN-1:0] issue_pc,
    input  wire                      stall_out,
    output logic [31:0]              mismatch_count,
    output logic [31:0]              rule_count,
    output logic [31:0]              issue_count,
    output logic                     timed_out
);
    import cpu_pkg::*;

    localparam int TIME_LIMIT = NUM_ISSUES * (MEM_LATENCY + 2) + 200;

    logic [XLEN-1:0] prog [MEM_WORDS];  // Own copy of what the load port wrote
    logic [XLEN-1:0] exp_pc;
    logic            after_jump;
    logic            was_held;          // A fetched word sat behind stall_in last cycle
    int              jump_gap;
    int              cycles;
    int              stall_cycles;

    function automatic int slot(input logic [XLEN-1:0] addr);
        return int'((addr / INSTR_BYTES) % MEM_WORDS);
    endfunction

    // Next PC from the current PC and the word found there
    function automatic logic [XLEN-1:0] expected_next_pc(input logic [XLEN-1:0] pc,
                                                         input logic [XLEN-1:0] instr);
        logic [20:0] offset;
        int          offset_int;
        if (instr[6:0] != OP_JAL) begin
            return pc + INSTR_BYTES;
        end
        offset     = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        offset_int = $signed(offset);
        return pc + XLEN'(offset_int);
    endfunction

    always @(posedge f_clk) begin
        if (load_en) begin
            prog[slot(load_addr)] <= load_data;
        end
    end

    always @(posedge f_clk or negedge f_rst) begin : watch
        int              new_mm;
        int              new_rule;
        logic [XLEN-1:0] exp_instr;
        if (!f_rst) begin
            exp_pc         <= RESET_PC;
            after_jump     <= 1'b0;
            was_held       <= 1'b0;
            jump_gap       <= 0;
            cycles         <= 0;
            stall_cycles   <= 0;
            mismatch_count <= '0;
            rule_count     <= '0;
            issue_count    <= '0;
            timed_out      <= 1'b0;
        end else begin
            new_mm   = 0;
            new_rule = 0;
            cycles <= cycles + 1;
            if (stall_in) begin
                stall_cycles <= stall_cycles + 1;
            end
            if (!run && (issue_valid || stall_out)) begin
                $display("Front end active before run: issue_valid=%b stall_out=%b",
                         issue_valid, stall_out);
                new_rule++;
            end
            if (issue_valid && stall_in) begin
                $display("A word was issued while stall_in was high, at PC %h", issue_pc);
                new_rule++;
            end
            if (stall_out && !stall_in) begin
                $display("stall_out was high while stall_in was low");
                new_rule++;
            end
            if (was_held && stall_in && !stall_out) begin
                $display("stall_out fell while a word was still held behind stall_in");
                new_rule++;
            end
            if (was_held && !stall_in && !issue_valid) begin
                $display("A held word was not issued in the first cycle after stall_in fell");
                new_rule++;
            end
            was_held <= stall_out;
            if (issue_valid) begin
                exp_instr = prog[slot(exp_pc)];
                if (issue_pc !== exp_pc) begin
                    $display("Mismatch issue_pc: expected %h, got %h", exp_pc, issue_pc);
                    new_mm++;
                end
                if (issue_instr !== exp_instr) begin
                    $display("Mismatch issue_instr: expected %h, got %h", exp_instr, issue_instr);
                    new_mm++;
                end
                // Gap counts unstalled cycles from the JAL to this issue
                if (after_jump && jump_gap + 1 > MEM_LATENCY + 3) begin
                    $display("Redirected word came %0d cycles after the jump, limit is %0d",
                             jump_gap + 1, MEM_LATENCY + 3);
                    new_rule++;
                end
                exp_pc      <= expected_next_pc(exp_pc, exp_instr);
                after_jump  <= (exp_instr[6:0] == OP_JAL);
                jump_gap    <= 0;
                issue_count <= issue_count + 1;
            end else if (after_jump && !stall_in) begin
                jump_gap <= jump_gap + 1;
            end
            if (!timed_out && issue_count < NUM_ISSUES && cycles >= TIME_LIMIT + stall_cycles) begin
                $display("Timeout: only %0d of %0d words issued after %0d cycles",
                         issue_count, NUM_ISSUES, cycles);
                timed_out <= 1'b1;
                new_rule++;
            end
            mismatch_count <= mismatch_count + new_mm;
            rule_count     <= rule_count + new_rule;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int MEM_WORDS   = 64,
    parameter int MEM_LATENCY = 2
) (
    input  wire                      f_clk,
    input  wire                      f_rst,
    input  wire                      run,
    input  wire                      stall_in,
    input  wire                      load_en,
    input  wire  [cpu_pkg::XLEN-1:0] load_addr,
    input  wire  [cpu_pkg::XLEN-1:0] load_data,
    output logic                     issue_valid,
    output logic [cpu_pkg::XLEN-1:0] issue_instr,
    output logic [cpu_pkg::XLEN-1:0] issue_pc,
    output logic                     stall_out
);
    import cpu_pkg::*;

    // Memory request path
    logic            imem_syn;
    logic [XLEN-1:0] imem_addr;
    logic            imem_ack;
    logic [XLEN-1:0] imem_data;

    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            flush;

    instruction_fetch u_fetch (
        .f_clk       (f_clk),
        .f_rst       (f_rst),
        .run         (run),
        .imem_ack    (imem_ack),
        .imem_data   (imem_data),
        .stall_in    (stall_in),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .imem_syn    (imem_syn),
        .imem_addr   (imem_addr),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .stall_out   (stall_out)
    );

    instr_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_imem (
        .f_clk     (f_clk),
        .f_rst     (f_rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .imem_syn  (imem_syn),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_data (imem_data)
    );

    // Sees the same issued words that leave the top level
    jump_resolver u_jump (
        .f_clk       (f_clk),
        .f_rst       (f_rst),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush)
    );

endmodule

`default_nettype wire

// File: verilog/jump_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module jump_resolver (
    input  wire                      f_clk,
    input  wire                      f_rst,
    input  wire                      issue_valid,
    input  wire  [cpu_pkg::XLEN-1:0] issue_instr,
    input  wire  [cpu_pkg::XLEN-1:0] issue_pc,
    output logic                     redirect,
    output logic [cpu_pkg::XLEN-1:0] redirect_pc,
    output logic                     flush
);
    import cpu_pkg::*;

    logic            jump;     // One strobe drives both redirect and flush
    logic            is_jal;
    logic [XLEN-1:0] target;

    // J-type immediate, sign-extended with bit 0 forced to zero
    function automatic logic [XLEN-1:0] j_imm(input logic [XLEN-1:0] instr);
        return {{(XLEN-20){instr[XLEN-1]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

    assign is_jal = issue_valid && (issue_instr[OPCODE_W-1:0] == OP_JAL);
    assign target = issue_pc + j_imm(issue_instr);

    assign redirect = jump;
    assign flush    = jump;

    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            jump <= 1'b0;
        end else begin
            jump <= is_jal;
        end
    end

    always_ff @(posedge f_clk) begin
        if (is_jal) begin
            redirect_pc <= target;
        end
    end

endmodule

`default_nettype wire

// File: verilog/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch (
    input  wire                      f_clk,
    input  wire                      f_rst,
    input  wire                      run,
    input  wire                      imem_ack,
    input  wire  [cpu_pkg::XLEN-1:0] imem_data,
    input  wire                      stall_in,
    input  wire                      redirect,
    input  wire  [cpu_pkg::XLEN-1:0] redirect_pc,
    input  wire                      flush,
    output logic                     imem_syn,
    output logic [cpu_pkg::XLEN-1:0] imem_addr,
    output logic                     issue_valid,
    output logic [cpu_pkg::XLEN-1:0] issue_instr,
    output logic [cpu_pkg::XLEN-1:0] issue_pc,
    output logic                     stall_out
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc;          // Address of the current or next request
    logic            req;
    logic            absorb;      // An ack for a flushed request is still on its way
    logic            hold_valid;
    logic [XLEN-1:0] hold_instr;
    logic [XLEN-1:0] hold_pc;
    logic            take_ack;
    logic            launch;

    // An ack that lands together with a flush belongs to the old path
    assign take_ack = imem_ack && req && !flush;

    // A new request waits until the previous word has left the stage.
    // This leaves a gap where a redirect from the word just issued can
    // still steer the request that follows.
    assign launch = run && !req && !absorb && !hold_valid;

    assign imem_syn    = req;
    assign imem_addr   = pc;
    assign issue_valid = hold_valid && !stall_in && !flush;
    assign issue_instr = hold_instr;
    assign issue_pc    = hold_pc;
    assign stall_out   = hold_valid && stall_in;  // A fetched word is held back

    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            pc     <= RESET_PC;
            req    <= 1'b0;
            absorb <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (take_ack) begin
                pc <= pc + XLEN'(INSTR_BYTES);
            end

            if (launch) begin
                req <= 1'b1;
            end else if (imem_ack || flush) begin
                req <= 1'b0;
            end

            // The memory still answers a request that was dropped, so its ack is swallowed
            if (imem_ack) begin
                absorb <= 1'b0;
            end else if (flush && req) begin
                absorb <= 1'b1;
            end
        end
    end

    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            hold_valid <= 1'b0;
        end else if (take_ack) begin
            hold_valid <= 1'b1;
        end else if (flush || issue_valid) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge f_clk) begin
        if (take_ack) begin
            hold_instr <= imem_data;
            hold_pc    <= pc;       // pc still points at the acked request here
        end
    end

endmodule

`default_nettype wire

// File: verilog/instr_memory.sv
`timescale 1ns/1ps
`default_nettype none

module instr_memory #(
    parameter int MEM_WORDS   = 64,
    parameter int MEM_LATENCY = 2
) (
    input  wire                      f_clk,
    input  wire                      f_rst,
    input  wire                      load_en,
    input  wire  [cpu_pkg::XLEN-1:0] load_addr,
    input  wire  [cpu_pkg::XLEN-1:0] load_data,
    input  wire                      imem_syn,
    input  wire  [cpu_pkg::XLEN-1:0] imem_addr,
    output logic                     imem_ack,
    output logic [cpu_pkg::XLEN-1:0] imem_data
);
    import cpu_pkg::*;

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [AW-1:0]   rd_idx;     // Word index of the request being served
    logic [AW-1:0]   rd_sel;
    logic            busy;
    logic [2:0]      cnt;        // Cycles left until the ack
    logic            start;
    logic            ack_next;

    // Byte address to word slot, wrapping at the memory depth
    function automatic logic [AW-1:0] word_index(input logic [XLEN-1:0] addr);
        return AW'((addr / XLEN'(INSTR_BYTES)) % XLEN'(MEM_WORDS));
    endfunction

    // The request is still high in its ack cycle and must not restart the counter
    assign start    = imem_syn && !imem_ack && !busy;
    assign ack_next = busy ? (cnt == 3'd1) : (start && MEM_LATENCY == 1);
    assign rd_sel   = busy ? rd_idx : word_index(imem_addr);

    always_ff @(posedge f_clk) begin
        if (load_en) begin
            mem[word_index(load_addr)] <= load_data;
        end
    end

    always_ff @(posedge f_clk or negedge f_rst) begin
        if (!f_rst) begin
            busy     <= 1'b0;
            cnt      <= 3'd0;
            imem_ack <= 1'b0;
        end else begin
            imem_ack <= ack_next;
            if (busy) begin
                cnt <= cnt - 3'd1;
                if (cnt == 3'd1) begin
                    busy <= 1'b0;
                end
            end else if (start && MEM_LATENCY > 1) begin
                busy <= 1'b1;
                cnt  <= 3'(MEM_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge f_clk) begin
        if (start) begin
            rd_idx <= word_index(imem_addr);  // Later address changes do not affect this read
        end
        if (ack_next) begin
            imem_data <= mem[rd_sel];
        end
    end

endmodule

`default_nettype wire

// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Width of the PC, of every address and of an instruction word
    parameter int XLEN = 32;

    // Byte step between two consecutive instruction words
    parameter int INSTR_BYTES = 4;

    parameter logic [XLEN-1:0] RESET_PC = '0;  // First address fetched after reset

    parameter int OPCODE_W = 7;  // Opcode sits in the low bits of the word

    // Major opcode of the jump-and-link instruction
    parameter logic [OPCODE_W-1:0] OP_JAL = 7'b1101111;

endpackage

`default_nettype wire
